// File: Makefile
# Verilator build for the peripheral bus testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_periph_bus
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

SOURCES   = $(shell cat $(FILELIST))
SIM_BIN   = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_periph_bus.sv
/*
 * peripheral bus testbench
 * directed tests over the cpu mmio bus: status leds, dsp multiplier,
 * mock gamepad, unmapped regions and the fixed response latency
 */

`timescale 1ns/100ps

module tb_periph_bus
    import bus_pkg::*;
    import periph_pkg::*;
();

    localparam int clk_period = 10;
    localparam int reset_cycles = 5;
    localparam int bus_latency = 3;
    localparam int num_tests = 5;
    localparam int max_accesses = 64;
    localparam int access_cycles = 8;
    localparam int watchdog_ns =
        (reset_cycles + num_tests * max_accesses * access_cycles) * clk_period;

    // operand pairs at the corners of the signed 16-bit range
    localparam logic [15:0] extreme_a [4] = '{16'h8000, 16'h7fff, 16'h8000, 16'hffff};
    localparam logic [15:0] extreme_b [4] = '{16'h8000, 16'h7fff, 16'h7fff, 16'h8000};
    localparam logic [3:0] unmapped_regions [4] = '{4'h0, 4'h3, 4'h8, 4'hf};

    logic vdp_clk;
    logic vdp_reset;
    logic cpu_mem_valid;
    logic [addr_width-1:0] cpu_address;
    logic [3:0] cpu_wstrb;
    logic [data_width-1:0] cpu_write_data;
    logic btn_1;
    logic btn_2;
    logic btn_3;
    logic cpu_mem_ready;
    logic [data_width-1:0] cpu_read_data;
    logic led_r;
    logic led_b;

    logic [31:0] lfsr_state;
    logic [data_width-1:0] last_product;
    int error_count;
    int check_count;
    int tests_run;
    int tests_failed;
    int test_errors_start;

    periph_bus_top DUT (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .cpu_mem_valid(cpu_mem_valid),
        .cpu_address(cpu_address),
        .cpu_wstrb(cpu_wstrb),
        .cpu_write_data(cpu_write_data),
        .btn_1(btn_1),
        .btn_2(btn_2),
        .btn_3(btn_3),
        .cpu_mem_ready(cpu_mem_ready),
        .cpu_read_data(cpu_read_data),
        .led_r(led_r),
        .led_b(led_b)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #(clk_period / 2) vdp_clk = ~vdp_clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the bus hung", watchdog_ns);
        $display("Done: errors found");
        $finish;
    end

    // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic host_addr_u make_addr(input logic [3:0] region, input logic [1:0] index);
        host_addr_u addr;
        addr.raw = '0;
        addr.field.region = region;
        addr.field.index = index;
        return addr;
    endfunction

    task automatic check_word(input string name, input logic [data_width-1:0] expected,
                              input logic [data_width-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
        end
    endtask

    // one cpu access, driven on the falling edge and held until ready
    task automatic bus_access(input host_addr_u addr, input logic [3:0] wstrb,
                              input logic [data_width-1:0] wdata,
                              output logic [data_width-1:0] rdata);
        int cycles;
        cycles = 0;
        rdata = 'x;
        @(negedge vdp_clk);
        cpu_mem_valid = 1'b1;
        cpu_address = addr.raw;
        cpu_wstrb = wstrb;
        cpu_write_data = wdata;
        // valid is sampled here
        @(posedge vdp_clk);
        @(negedge vdp_clk);
        while (!cpu_mem_ready && cycles < access_cycles) begin
            cycles++;
            @(negedge vdp_clk);
        end
        if (!cpu_mem_ready) begin
            error_count++;
            $display("no cpu_mem_ready within %0d cycles of valid, at %0t",
                     access_cycles, $time);
        end else begin
            rdata = cpu_read_data;
            check_count++;
            if (cycles != bus_latency) begin
                error_count++;
                $display("CHECK FAILED at %0t: cpu_mem_ready latency expected %0d, got %0d",
                         $time, bus_latency, cycles);
            end
        end
        cpu_mem_valid = 1'b0;
        cpu_wstrb = '0;
        @(negedge vdp_clk);
        check_bit("cpu_mem_ready pulse end", 1'b0, cpu_mem_ready);
    endtask

    task automatic bus_write(input host_addr_u addr, input logic [data_width-1:0] wdata);
        logic [data_width-1:0] rdata;
        bus_access(addr, 4'hf, wdata, rdata);
        check_word("cpu_read_data on write", '0, rdata);
    endtask

    task automatic bus_read(input host_addr_u addr, output logic [data_width-1:0] rdata);
        bus_access(addr, 4'h0, '0, rdata);
    endtask

    task automatic start_test();
        test_errors_start = error_count;
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = error_count - test_errors_start;
        tests_run++;
        if (errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors);
        end
    endtask

    task automatic test_reset();
        logic [data_width-1:0] rdata;
        check_bit("cpu_mem_ready", 1'b0, cpu_mem_ready);
        check_bit("led_r", 1'b1, led_r);
        check_bit("led_b", 1'b0, led_b);
        bus_read(make_addr(region_io, reg_status), rdata);
        check_word("status read", {30'b0, status_reset_value}, rdata);
    endtask

    task automatic test_status();
        logic [31:0] value;
        logic [data_width-1:0] rdata;
        int i;
        for (i = 0; i < 6; i++) begin
            random_bits(2, value);
            bus_write(make_addr(region_io, reg_status), value);
            check_bit("led_r", value[0], led_r);
            check_bit("led_b", value[1], led_b);
            bus_read(make_addr(region_io, reg_status), rdata);
            check_word("status read", {30'b0, value[1:0]}, rdata);
        end
    endtask

    task automatic test_mult();
        logic [31:0] word;
        logic [15:0] op_a;
        logic [15:0] op_b;
        logic signed [31:0] ext_a;
        logic signed [31:0] ext_b;
        logic signed [31:0] expected;
        logic [data_width-1:0] rdata;
        int i;
        for (i = 0; i < 20; i++) begin
            if (i < 4) begin
                op_a = extreme_a[i];
                op_b = extreme_b[i];
            end else begin
                random_bits(16, word);
                op_a = word[15:0];
                random_bits(16, word);
                op_b = word[15:0];
            end
            ext_a = {{16{op_a[15]}}, op_a};
            ext_b = {{16{op_b[15]}}, op_b};
            expected = ext_a * ext_b;
            // upper half is junk the multiplier must ignore
            bus_write(make_addr(region_dsp, reg_dsp_a), {16'ha5a5, op_a});
            bus_write(make_addr(region_dsp, reg_dsp_b), {16'h5a5a, op_b});
            bus_read(make_addr(region_dsp, i[0] ? reg_dsp_b : reg_dsp_a), rdata);
            check_word("dsp product", expected, rdata);
            last_product = expected;
        end
    endtask

    task automatic test_pad();
        logic [31:0] word;
        logic [pad_width-1:0] expected_pad;
        logic [data_width-1:0] rdata;
        int i;
        random_bits(3, word);
        btn_1 = word[0];
        btn_2 = word[1];
        btn_3 = word[2];
        expected_pad = '0;
        expected_pad[pad_bit_b] = btn_2;
        expected_pad[pad_bit_right] = btn_3;
        expected_pad[pad_bit_left] = btn_1;
        bus_write(make_addr(region_io, reg_pad), 32'd1);
        bus_write(make_addr(region_io, reg_pad), 32'd0);
        // new button levels must not reach the closed latch
        btn_1 = ~btn_1;
        btn_2 = ~btn_2;
        btn_3 = ~btn_3;
        for (i = 0; i < pad_width; i++) begin
            bus_read(make_addr(region_io, reg_pad), rdata);
            check_bit($sformatf("pad bit %0d", i), expected_pad[i], rdata[0]);
            bus_write(make_addr(region_io, reg_pad), 32'd2);
            bus_write(make_addr(region_io, reg_pad), 32'd0);
        end
        bus_read(make_addr(region_io, reg_pad), rdata);
        check_bit("pad bit after shift out", 1'b0, rdata[0]);
    endtask

    task automatic test_unmapped();
        logic led_r_before;
        logic led_b_before;
        logic [data_width-1:0] rdata;
        int i;
        led_r_before = led_r;
        led_b_before = led_b;
        for (i = 0; i < 4; i++) begin
            // a misrouted write would flip the leds or change a dsp operand
            bus_write(make_addr(unmapped_regions[i], 2'd0), {30'b0, ~led_b, ~led_r});
            bus_read(make_addr(unmapped_regions[i], 2'd1), rdata);
            check_word("unmapped read", '0, rdata);
        end
        check_bit("led_r", led_r_before, led_r);
        check_bit("led_b", led_b_before, led_b);
        bus_read(make_addr(region_dsp, reg_dsp_a), rdata);
        check_word("dsp product", last_product, rdata);
    endtask

    initial begin
        lfsr_state = 32'h52cf;
        last_product = '0;
        error_count = 0;
        check_count = 0;
        tests_run = 0;
        tests_failed = 0;
        test_errors_start = 0;
        vdp_reset = 1'b1;
        cpu_mem_valid = 1'b0;
        cpu_address = '0;
        cpu_wstrb = '0;
        cpu_write_data = '0;
        btn_1 = 1'b0;
        btn_2 = 1'b0;
        btn_3 = 1'b0;
        repeat (reset_cycles) @(negedge vdp_clk);
        vdp_reset = 1'b0;
        @(negedge vdp_clk);

        start_test();
        test_reset();
        finish_test("reset");
        start_test();
        test_status();
        finish_test("status leds");
        start_test();
        test_mult();
        finish_test("dsp multiply");
        start_test();
        test_pad();
        finish_test("gamepad shift");
        start_test();
        test_unmapped();
        finish_test("unmapped regions");

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: build.f
src/bus_pkg.sv
src/periph_pkg.sv
src/periph_if.sv
src/mmio_decoder.sv
src/dsp_mult.sv
src/io_regs.sv
src/mmio_arbiter.sv
src/periph_bus_top.sv
bench/tb_periph_bus.sv

// File: src/bus_pkg.sv
/*
 * host bus package
 * widths of the cpu bus, the address map regions and the
 * address word that the decoder and testbench share
 */

package bus_pkg;

    localparam int addr_width = 24;
    localparam int data_width = 32;
    localparam int index_width = 2;

    // 4-bit region field at the top of the address
    localparam logic [3:0] region_dsp = 4'd1;
    localparam logic [3:0] region_io = 4'd2;

    // field view of a host address
    typedef struct packed {
        logic [3:0] region;
        logic [15:0] unused;
        logic [index_width-1:0] index;
        logic [1:0] byte_offset;
    } host_addr_fields_t;

    // one address word, seen raw or split into fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        host_addr_fields_t field;
    } host_addr_u;

endpackage

// File: src/dsp_mult.sv
/*
 * dsp multiplier
 * two 16-bit operand registers and a signed product register,
 * read back as a 32-bit word
 */

`timescale 1ns/100ps

module dsp_mult
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  logic vdp_clk,
    periph_if.periph bus
);

    logic signed [15:0] op_a;
    logic signed [15:0] op_b;
    logic signed [31:0] product;
    logic ready_r;
    logic [data_width-1:0] read_data_r;

    // operand registers take the low half of the write word
    always_ff @(posedge vdp_clk) begin
        if (bus.en && bus.write_en && bus.index == reg_dsp_a) begin
            op_a <= bus.write_data[15:0];
        end

        if (bus.en && bus.write_en && bus.index == reg_dsp_b) begin
            op_b <= bus.write_data[15:0];
        end

        // signed 16x16 product updated every cycle
        product <= op_a * op_b;
    end

    always_ff @(posedge vdp_clk) begin
        ready_r <= bus.en;
        // writes answer with zero
        if (bus.en) begin
            read_data_r <= bus.write_en ? '0 : product;
        end
    end

    assign bus.ready = ready_r;
    assign bus.read_data = read_data_r;

    a_ready_follows_en: assert property (@(posedge vdp_clk)
        (bus.en |=> bus.ready) and (bus.ready |-> $past(bus.en)));

endmodule

// File: src/io_regs.sv
/*
 * i/o register block
 * status leds and a mock gamepad shift register loaded from
 * the three board buttons
 */

`timescale 1ns/100ps

module io_regs
    import bus_pkg::*;
    import periph_pkg::*;
(
    input  logic vdp_clk,
    input  logic vdp_reset,
    periph_if.periph bus,

    input  logic btn_1,
    input  logic btn_2,
    input  logic btn_3,

    output logic led_r,
    output logic led_b
);

    logic [1:0] status;
    logic [1:0] pad_ctrl;
    logic pad_clk_r;
    logic [pad_width-1:0] pad_state;
    logic [pad_width-1:0] pad_buttons;
    logic ready_r;
    logic [data_width-1:0] read_word;
    logic [data_width-1:0] read_data_r;

    logic status_write;
    logic pad_write;
    logic pad_latch;
    logic pad_clk;

    assign status_write = bus.en && bus.write_en && bus.index == reg_status;
    assign pad_write = bus.en && bus.write_en && bus.index == reg_pad;
    assign pad_latch = pad_ctrl[0];
    assign pad_clk = pad_ctrl[1];

    // only left, right and b come from buttons
    always_comb begin
        pad_buttons = '0;
        pad_buttons[pad_bit_b] = btn_2;
        pad_buttons[pad_bit_right] = btn_3;
        pad_buttons[pad_bit_left] = btn_1;
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= status_reset_value;
            pad_ctrl <= 2'b00;
            pad_clk_r <= 1'b0;
            pad_state <= '0;
            ready_r <= 1'b0;
        end else begin
            ready_r <= bus.en;

            if (status_write) begin
                status <= bus.write_data[1:0];
            end
            if (pad_write) begin
                pad_ctrl <= bus.write_data[1:0];
            end

            if (pad_latch) begin
                pad_state <= pad_buttons;
            end
            // rising pad clock shifts right with zero fill at the top
            if (pad_clk && !pad_clk_r) begin
                pad_state <= {1'b0, pad_state[pad_width-1:1]};
            end
            pad_clk_r <= pad_clk;
        end
    end

    always_comb begin
        read_word = '0;
        if (!bus.write_en) begin
            case (bus.index)
                reg_status: read_word[1:0] = status;
                reg_pad: read_word[0] = pad_state[0];
                default: read_word = '0;
            endcase
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (bus.en) begin
            read_data_r <= read_word;
        end
    end

    assign bus.ready = ready_r;
    assign bus.read_data = read_data_r;
    assign led_r = status[0];
    assign led_b = status[1];

endmodule

// File: src/mmio_arbiter.sv
/*
 * mmio bus arbiter
 * merges the peripheral responses and the unmapped flag into
 * one registered ready and read word for the cpu
 */

`timescale 1ns/100ps

module mmio_arbiter
    import bus_pkg::*;
(
    input  logic vdp_clk,
    input  logic vdp_reset,

    periph_if.arbiter dsp_bus,
    periph_if.arbiter io_bus,
    input  logic unmapped,

    output logic cpu_mem_ready,
    output logic [data_width-1:0] cpu_read_data
);

    logic unmapped_d;
    logic any_ready;
    logic [data_width-1:0] sel_data;

    // unmapped pulse delayed to line up with peripheral ready
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            unmapped_d <= 1'b0;
        end else begin
            unmapped_d <= unmapped;
        end
    end

    assign any_ready = dsp_bus.ready || io_bus.ready || unmapped_d;

    always_comb begin
        if (dsp_bus.ready) begin
            sel_data = dsp_bus.read_data;
        end else if (io_bus.ready) begin
            sel_data = io_bus.read_data;
        end else begin
            // unmapped or idle
            sel_data = '0;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            cpu_mem_ready <= 1'b0;
        end else begin
            cpu_mem_ready <= any_ready;
        end
    end

    always_ff @(posedge vdp_clk) begin
        cpu_read_data <= sel_data;
    end

    a_single_responder: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        !(dsp_bus.ready && io_bus.ready));

    // one access in flight means ready is never two cycles wide
    a_ready_pulse: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        cpu_mem_ready |=> !cpu_mem_ready);

endmodule

// File: src/mmio_decoder.sv
/*
 * mmio address decoder
 * captures one cpu access at a time and turns it into a single
 * enable pulse for the dsp or i/o block, or an unmapped pulse
 */

`timescale 1ns/100ps

module mmio_decoder
    import bus_pkg::*;
(
    input  logic vdp_clk,
    input  logic vdp_reset,

    input  logic cpu_mem_valid,
    input  host_addr_u cpu_address,
    input  logic [3:0] cpu_wstrb,
    input  logic [data_width-1:0] cpu_write_data,
    input  logic cpu_mem_ready,

    output logic unmapped,
    periph_if.decoder dsp_bus,
    periph_if.decoder io_bus
);

    logic busy;
    logic pending;
    logic accept;
    logic dsp_en;
    logic io_en;
    logic unmapped_r;

    host_addr_u addr_r;
    logic write_r;
    logic [data_width-1:0] wdata_r;

    // only one access in flight until the response is seen
    assign accept = !busy && cpu_mem_valid;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            busy <= 1'b0;
            pending <= 1'b0;
            dsp_en <= 1'b0;
            io_en <= 1'b0;
            unmapped_r <= 1'b0;
        end else begin
            dsp_en <= 1'b0;
            io_en <= 1'b0;
            unmapped_r <= 1'b0;

            if (accept) begin
                busy <= 1'b1;
                pending <= 1'b1;
            end else if (cpu_mem_ready) begin
                busy <= 1'b0;
            end

            // one cycle after capture, fire the enable for the region
            if (pending) begin
                pending <= 1'b0;
                case (addr_r.field.region)
                    region_dsp: dsp_en <= 1'b1;
                    region_io: io_en <= 1'b1;
                    default: unmapped_r <= 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            addr_r <= cpu_address;
            write_r <= |cpu_wstrb;
            wdata_r <= cpu_write_data;
        end
    end

    assign unmapped = unmapped_r;

    assign dsp_bus.en = dsp_en;
    assign dsp_bus.write_en = write_r;
    assign dsp_bus.index = addr_r.field.index;
    assign dsp_bus.write_data = wdata_r;

    assign io_bus.en = io_en;
    assign io_bus.write_en = write_r;
    assign io_bus.index = addr_r.field.index;
    assign io_bus.write_data = wdata_r;

    // each access lands on exactly one target
    a_one_target: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $onehot0({dsp_bus.en, io_bus.en, unmapped}));

endmodule

// File: src/periph_bus_top.sv
/*
 * peripheral bus top
 * cpu mmio slice with decoder, dsp multiplier, i/o registers
 * and response arbiter on the video clock
 */

`timescale 1ns/100ps

module periph_bus_top
    import bus_pkg::*;
(
    input  logic vdp_clk,
    input  logic vdp_reset,

    input  logic cpu_mem_valid,
    input  logic [addr_width-1:0] cpu_address,
    input  logic [3:0] cpu_wstrb,
    input  logic [data_width-1:0] cpu_write_data,

    input  logic btn_1,
    input  logic btn_2,
    input  logic btn_3,

    output logic cpu_mem_ready,
    output logic [data_width-1:0] cpu_read_data,

    output logic led_r,
    output logic led_b
);

    logic unmapped;

    periph_if dsp_bus ();
    periph_if io_bus ();

    mmio_decoder decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .cpu_mem_valid(cpu_mem_valid),
        .cpu_address(host_addr_u'(cpu_address)),
        .cpu_wstrb(cpu_wstrb),
        .cpu_write_data(cpu_write_data),
        .cpu_mem_ready(cpu_mem_ready),
        .unmapped(unmapped),
        .dsp_bus(dsp_bus.decoder),
        .io_bus(io_bus.decoder)
    );

    dsp_mult dsp (
        .vdp_clk(vdp_clk),
        .bus(dsp_bus.periph)
    );

    io_regs io (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(io_bus.periph),
        .btn_1(btn_1),
        .btn_2(btn_2),
        .btn_3(btn_3),
        .led_r(led_r),
        .led_b(led_b)
    );

    mmio_arbiter arbiter (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .dsp_bus(dsp_bus.arbiter),
        .io_bus(io_bus.arbiter),
        .unmapped(unmapped),
        .cpu_mem_ready(cpu_mem_ready),
        .cpu_read_data(cpu_read_data)
    );

endmodule

// File: src/periph_if.sv
/*
 * peripheral bus interface
 * one access from the decoder to a peripheral and the
 * peripheral's response back to the arbiter
 */

`timescale 1ns/100ps

interface periph_if
    import bus_pkg::*;
();

    logic en;
    logic write_en;
    logic [index_width-1:0] index;
    logic [data_width-1:0] write_data;
    logic [data_width-1:0] read_data;
    logic ready;

    modport decoder (
        output en, write_en, index, write_data
    );

    modport periph (
        input en, write_en, index, write_data,
        output read_data, ready
    );

    modport arbiter (
        input ready, read_data
    );

endinterface

// File: src/periph_pkg.sv
/*
 * peripheral package
 * register indices of the dsp and i/o blocks, status reset value
 * and the button positions in the mock gamepad register
 */

package periph_pkg;

    // dsp operand indices that both read back the product
    localparam logic [1:0] reg_dsp_a = 2'd0;
    localparam logic [1:0] reg_dsp_b = 2'd1;

    // i/o block
    localparam logic [1:0] reg_status = 2'd0;
    localparam logic [1:0] reg_pad = 2'd1;

    // red led lit out of reset
    localparam logic [1:0] status_reset_value = 2'b01;

    localparam int pad_width = 16;
    localparam int pad_bit_b = 0;
    localparam int pad_bit_right = 6;
    localparam int pad_bit_left = 7;

endpackage
